/* Bender.yml */
package:
  name: csr_unit

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/csr_pkg.sv
      - hdl/csr_counters.sv
      - hdl/csr_regs.sv
      - hdl/csr_response.sv
      - hdl/csr_unit.sv
      - target: test
        files:
          - tb/csr_unit_sva.sv
          - tb/csr_unit_tb.sv

/* hdl/csr_config.svh */
// csr unit build constants; MISA_VALUE in csr_pkg assumes CSR_XLEN stays 32, timer width 2x xlen
`ifndef CSR_CONFIG_SVH
`define CSR_CONFIG_SVH

// ********************
// data path widths
// ********************

// one csr data word
`define CSR_XLEN 32

// cycle / time / instret counters, read as low and high halves
`define CSR_TIMER_W 64

// ********************
// reset and id values
// ********************

// single hart system
`define CSR_HART_ID 32'h0000_0000

// trap vector after reset, direct mode so low bits stay zero
`define CSR_MTVEC_RESET 32'h0000_0100

`endif

/* hdl/csr_counters.sv */
// counter bank; all counter csrs are read-only, writes through op/wdata are not seen here
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_counters (
    input logic clk,
    input logic rst,
    input logic req,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::priv_t priv,
    input logic retire,
    input logic retire_no_rd,
    output logic cnt_hit,
    output logic cnt_denied,
    output csr_pkg::xlen_t cnt_data
);

    logic [1:0] ret_inc;
    csr_pkg::timer_t mcycle;
    csr_pkg::timer_t mtime;
    csr_pkg::timer_t minstret;

    logic sel_hit;
    csr_pkg::xlen_t sel_data;

    // ********************
    // counters
    // ********************

    // retire increment, one cycle behind the pulses
    always_ff @(posedge clk) begin
        if (rst) begin
            ret_inc <= 2'd0;
        end else if (retire && retire_no_rd) begin
            ret_inc <= 2'd2;
        end else if (retire || retire_no_rd) begin
            ret_inc <= 2'd1;
        end else begin
            ret_inc <= 2'd0;
        end
    end

    // time runs off the core clock, same as cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle <= '0;
            mtime <= '0;
            minstret <= '0;
        end else begin
            mcycle <= mcycle + 1'b1;
            mtime <= mtime + 1'b1;
            minstret <= minstret + csr_pkg::timer_t'(ret_inc);
        end
    end

    // ********************
    // read decode
    // ********************
    always_comb begin
        sel_hit = 1'b1;
        case (addr)
            csr_pkg::ADDR_MCYCLE, csr_pkg::ADDR_CYCLE:
                sel_data = mcycle[`CSR_XLEN-1:0];
            csr_pkg::ADDR_MCYCLEH, csr_pkg::ADDR_CYCLEH:
                sel_data = mcycle[`CSR_TIMER_W-1:`CSR_XLEN];
            csr_pkg::ADDR_TIME:
                sel_data = mtime[`CSR_XLEN-1:0];
            csr_pkg::ADDR_TIMEH:
                sel_data = mtime[`CSR_TIMER_W-1:`CSR_XLEN];
            csr_pkg::ADDR_MINSTRET, csr_pkg::ADDR_INSTRET:
                sel_data = minstret[`CSR_XLEN-1:0];
            csr_pkg::ADDR_MINSTRETH, csr_pkg::ADDR_INSTRETH:
                sel_data = minstret[`CSR_TIMER_W-1:`CSR_XLEN];
            default: begin
                sel_hit = 1'b0;
                sel_data = '0;
            end
        endcase
    end

    // hit, denied and data all land on the edge after req
    always_ff @(posedge clk) begin
        if (rst) begin
            cnt_hit <= 1'b0;
            cnt_denied <= 1'b0;
        end else if (req) begin
            cnt_hit <= sel_hit;
            cnt_denied <= sel_hit && (addr[9:8] > priv);
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            cnt_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_pkg.sv */
// shared csr types and address map; only the registers this unit implements are listed
`include "csr_config.svh"
`default_nettype none

package csr_pkg;

    // ********************
    // widths
    // ********************
    typedef logic [`CSR_XLEN-1:0] xlen_t;
    typedef logic [`CSR_TIMER_W-1:0] timer_t;
    // [11:10] access, [9:8] min privilege
    typedef logic [11:0] csr_addr_t;
    typedef logic [1:0] priv_t;
    typedef logic [1:0] csr_op_t;

    // privilege levels, hypervisor code unused
    localparam priv_t PRIV_USER = 2'd0;
    localparam priv_t PRIV_SUPERVISOR = 2'd1;
    localparam priv_t PRIV_MACHINE = 2'd3;

    // csr ops, anything else behaves as plain write
    localparam csr_op_t CSR_OP_RW = 2'd1;
    localparam csr_op_t CSR_OP_RS = 2'd2;
    localparam csr_op_t CSR_OP_RC = 2'd3;

    // access field value for read-only space
    localparam logic [1:0] ACCESS_RO = 2'b11;

    // ********************
    // address map
    // ********************
    // machine information
    localparam csr_addr_t ADDR_MISA = 12'h301;
    localparam csr_addr_t ADDR_MVENDORID = 12'hF11;
    localparam csr_addr_t ADDR_MARCHID = 12'hF12;
    localparam csr_addr_t ADDR_MIMPID = 12'hF13;
    localparam csr_addr_t ADDR_MHARTID = 12'hF14;
    // writable
    localparam csr_addr_t ADDR_MTVEC = 12'h305;
    localparam csr_addr_t ADDR_MSCRATCH = 12'h340;
    localparam csr_addr_t ADDR_SSCRATCH = 12'h140;
    // machine counters
    localparam csr_addr_t ADDR_MCYCLE = 12'hB00;
    localparam csr_addr_t ADDR_MINSTRET = 12'hB02;
    localparam csr_addr_t ADDR_MCYCLEH = 12'hB80;
    localparam csr_addr_t ADDR_MINSTRETH = 12'hB82;
    // user counters, read-only shadows
    localparam csr_addr_t ADDR_CYCLE = 12'hC00;
    localparam csr_addr_t ADDR_TIME = 12'hC01;
    localparam csr_addr_t ADDR_INSTRET = 12'hC02;
    localparam csr_addr_t ADDR_CYCLEH = 12'hC80;
    localparam csr_addr_t ADDR_TIMEH = 12'hC81;
    localparam csr_addr_t ADDR_INSTRETH = 12'hC82;

    // rv32, I M S U
    localparam xlen_t MISA_VALUE = 32'h4014_1100;

    // response stage
    typedef enum logic [0:0] {
        RESP_IDLE,
        RESP_DONE
    } resp_state_t;

endpackage

`default_nettype wire

/* hdl/csr_regs.sv */
// information and writable csrs; every op writes (no x0 suppression), misa writes are dropped
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_regs (
    input logic clk,
    input logic rst,
    input logic req,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::csr_op_t op,
    input csr_pkg::xlen_t wdata,
    input csr_pkg::priv_t priv,
    output logic reg_hit,
    output logic reg_denied,
    output csr_pkg::xlen_t reg_data
);

    csr_pkg::xlen_t mtvec;
    csr_pkg::xlen_t mscratch;
    csr_pkg::xlen_t sscratch;

    logic sel_hit;
    logic sel_denied;
    logic wr_ok;
    csr_pkg::xlen_t sel_data;
    csr_pkg::xlen_t upd_data;

    // ********************
    // read decode
    // ********************
    always_comb begin
        sel_hit = 1'b1;
        case (addr)
            // constant information
            csr_pkg::ADDR_MISA: sel_data = csr_pkg::MISA_VALUE;
            csr_pkg::ADDR_MVENDORID: sel_data = '0;
            csr_pkg::ADDR_MARCHID: sel_data = '0;
            csr_pkg::ADDR_MIMPID: sel_data = '0;
            csr_pkg::ADDR_MHARTID: sel_data = `CSR_HART_ID;
            // writable
            csr_pkg::ADDR_MTVEC: sel_data = mtvec;
            csr_pkg::ADDR_MSCRATCH: sel_data = mscratch;
            csr_pkg::ADDR_SSCRATCH: sel_data = sscratch;
            default: begin
                sel_hit = 1'b0;
                sel_data = '0;
            end
        endcase
    end

    // privilege check, only meaningful on a hit
    assign sel_denied = sel_hit && (addr[9:8] > priv);

    // read-only space never updates
    assign wr_ok = req && sel_hit && !sel_denied && (addr[11:10] != csr_pkg::ACCESS_RO);

    // ********************
    // update rule
    // ********************
    always_comb begin
        case (op)
            csr_pkg::CSR_OP_RS: upd_data = sel_data | wdata;
            csr_pkg::CSR_OP_RC: upd_data = sel_data & ~wdata;
            // rw and unused codes
            default: upd_data = wdata;
        endcase
    end

    // ********************
    // storage
    // ********************

    // mtvec, direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec <= `CSR_MTVEC_RESET;
        end else if (wr_ok && (addr == csr_pkg::ADDR_MTVEC)) begin
            mtvec <= {upd_data[`CSR_XLEN-1:2], 2'b00};
        end
    end

    // scratch pair
    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch <= '0;
            sscratch <= '0;
        end else if (wr_ok) begin
            if (addr == csr_pkg::ADDR_MSCRATCH) begin
                mscratch <= upd_data;
            end
            if (addr == csr_pkg::ADDR_SSCRATCH) begin
                sscratch <= upd_data;
            end
        end
    end

    // ********************
    // result
    // ********************

    // old value is returned, the write lands on the same edge
    always_ff @(posedge clk) begin
        if (rst) begin
            reg_hit <= 1'b0;
            reg_denied <= 1'b0;
        end else if (req) begin
            reg_hit <= sel_hit;
            reg_denied <= sel_denied;
        end
    end

    always_ff @(posedge clk) begin
        if (req) begin
            reg_data <= sel_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_response.sv */
// single-entry response stage; req only while ready, accepted only while done
`timescale 1ns/1ps
`default_nettype none

module csr_response (
    input logic clk,
    input logic rst,
    input logic req,
    input logic accepted,
    input logic cnt_hit,
    input logic cnt_denied,
    input logic reg_hit,
    input logic reg_denied,
    input csr_pkg::xlen_t cnt_data,
    input csr_pkg::xlen_t reg_data,
    output logic ready,
    output logic done,
    output logic illegal,
    output csr_pkg::xlen_t rdata
);

    csr_pkg::resp_state_t state;

    logic no_hit;

    // ********************
    // response fsm
    // ********************

    // idle -> done on req, back on accepted
    always_ff @(posedge clk) begin
        if (rst) begin
            state <= csr_pkg::RESP_IDLE;
        end else begin
            case (state)
                csr_pkg::RESP_IDLE: begin
                    if (req) begin
                        state <= csr_pkg::RESP_DONE;
                    end
                end
                csr_pkg::RESP_DONE: begin
                    // hold result under back-pressure
                    if (accepted) begin
                        state <= csr_pkg::RESP_IDLE;
                    end
                end
                default: state <= csr_pkg::RESP_IDLE;
            endcase
        end
    end

    assign ready = (state == csr_pkg::RESP_IDLE);
    assign done = (state == csr_pkg::RESP_DONE);

    // ********************
    // result merge
    // ********************

    // neither bank decoded the address
    assign no_hit = !cnt_hit && !reg_hit;

    // banks only flag denied on their own hits
    // qualified by done so the flag is quiet while idle
    assign illegal = done && (no_hit || cnt_denied || reg_denied);

    // bank outputs are already registered
    always_comb begin
        if (reg_hit) begin
            rdata = reg_data;
        end else if (cnt_hit) begin
            rdata = cnt_data;
        end else begin
            rdata = '0;
        end
    end

endmodule

`default_nettype wire

/* hdl/csr_unit.sv */
// csr unit top; priv is driven by the core, no trap, mstatus or translation state inside
`timescale 1ns/1ps
`default_nettype none

module csr_unit (
    input logic clk,
    input logic rst,
    // request from issue
    input logic req,
    input csr_pkg::csr_addr_t addr,
    input csr_pkg::csr_op_t op,
    input csr_pkg::xlen_t wdata,
    input csr_pkg::priv_t priv,
    // retire events
    input logic retire,
    input logic retire_no_rd,
    // writeback side
    input logic accepted,
    output logic ready,
    output logic done,
    output csr_pkg::xlen_t rdata,
    output logic illegal
);

    logic cnt_hit;
    logic cnt_denied;
    csr_pkg::xlen_t cnt_data;

    logic reg_hit;
    logic reg_denied;
    csr_pkg::xlen_t reg_data;

    // ********************
    // banks
    // ********************
    csr_counters u_counters (
        .clk(clk),
        .rst(rst),
        .req(req),
        .addr(addr),
        .priv(priv),
        .retire(retire),
        .retire_no_rd(retire_no_rd),
        .cnt_hit(cnt_hit),
        .cnt_denied(cnt_denied),
        .cnt_data(cnt_data)
    );

    csr_regs u_regs (
        .clk(clk),
        .rst(rst),
        .req(req),
        .addr(addr),
        .op(op),
        .wdata(wdata),
        .priv(priv),
        .reg_hit(reg_hit),
        .reg_denied(reg_denied),
        .reg_data(reg_data)
    );

    // ********************
    // response
    // ********************
    csr_response u_response (
        .clk(clk),
        .rst(rst),
        .req(req),
        .accepted(accepted),
        .cnt_hit(cnt_hit),
        .cnt_denied(cnt_denied),
        .reg_hit(reg_hit),
        .reg_denied(reg_denied),
        .cnt_data(cnt_data),
        .reg_data(reg_data),
        .ready(ready),
        .done(done),
        .illegal(illegal),
        .rdata(rdata)
    );

endmodule

`default_nettype wire

/* list.f */
+incdir+hdl
hdl/csr_pkg.sv
hdl/csr_counters.sv
hdl/csr_regs.sv
hdl/csr_response.sv
hdl/csr_unit.sv
tb/csr_unit_sva.sv
tb/csr_unit_tb.sv

/* tb/csr_unit_sva.sv */
// handshake assertions bound into csr_unit; assume req only while ready, accepted only while done
`timescale 1ns/1ps
`default_nettype none

module csr_unit_sva (
    input logic clk,
    input logic rst,
    input logic req,
    input logic accepted,
    input logic ready,
    input logic done
);

    // assertion failures so far
    int err_count = 0;

    // single item in flight, ready only comes back through accepted
    a_ready_after_accept: assert property (@(posedge clk) disable iff (rst)
        $rose(ready) |-> $past(accepted))
        else begin
            $error("ready rose without accepted");
            err_count++;
        end

    // result one edge after req
    a_done_after_req: assert property (@(posedge clk) disable iff (rst)
        req |=> done)
        else begin
            $error("done missing one cycle after req");
            err_count++;
        end

    // no result without a request
    a_done_needs_req: assert property (@(posedge clk) disable iff (rst)
        $rose(done) |-> $past(req))
        else begin
            $error("done rose without a request");
            err_count++;
        end

    // result held under back-pressure
    a_done_hold: assert property (@(posedge clk) disable iff (rst)
        (done && !accepted) |=> done)
        else begin
            $error("done fell before accepted");
            err_count++;
        end

endmodule

bind csr_unit csr_unit_sva u_sva (
    .clk(clk),
    .rst(rst),
    .req(req),
    .accepted(accepted),
    .ready(ready),
    .done(done)
);

`default_nettype wire

/* tb/csr_unit_tb.sv */
// table driven csr unit test; expects scratch regs to reset to 0 and retire inputs idle during reads
`timescale 1ns/1ps
`default_nettype none
`include "csr_config.svh"

module csr_unit_tb;

    localparam int TIMEOUT = 50;
    localparam int ROWS = 24;
    localparam int BURST = 10;
    // retire pattern, bit i drives cycle i of the burst
    localparam logic [BURST-1:0] RET_PAT = 10'b1101100111;
    localparam logic [BURST-1:0] NRD_PAT = 10'b0111010010;

    // short names for table rows
    localparam csr_pkg::csr_op_t OP_RW = csr_pkg::CSR_OP_RW;
    localparam csr_pkg::csr_op_t OP_RS = csr_pkg::CSR_OP_RS;
    localparam csr_pkg::csr_op_t OP_RC = csr_pkg::CSR_OP_RC;
    localparam csr_pkg::priv_t PRIV_M = csr_pkg::PRIV_MACHINE;
    localparam csr_pkg::priv_t PRIV_U = csr_pkg::PRIV_USER;

    logic clk;
    logic rst;
    logic req;
    csr_pkg::csr_addr_t addr;
    csr_pkg::csr_op_t op;
    csr_pkg::xlen_t wdata;
    csr_pkg::priv_t priv;
    logic retire;
    logic retire_no_rd;
    logic accepted;
    logic ready;
    logic done;
    csr_pkg::xlen_t rdata;
    logic illegal;

    integer seed = 32'h5c21_700e;
    integer edge_count = 0;
    integer n_rows;
    integer i;
    integer e1;
    integer e2;
    integer weight;
    csr_pkg::xlen_t got_data;
    csr_pkg::xlen_t cnt_a;
    csr_pkg::xlen_t cnt_b;
    logic got_ill;

    // stimulus and expectation table
    csr_pkg::csr_op_t tab_op [ROWS];
    csr_pkg::csr_addr_t tab_addr [ROWS];
    csr_pkg::xlen_t tab_wdata [ROWS];
    csr_pkg::priv_t tab_priv [ROWS];
    csr_pkg::xlen_t tab_exp [ROWS];
    logic tab_ill [ROWS];
    // data compare enable, off where the read value is unspecified
    logic tab_chk [ROWS];

    csr_unit DUT (
        .clk(clk),
        .rst(rst),
        .req(req),
        .addr(addr),
        .op(op),
        .wdata(wdata),
        .priv(priv),
        .retire(retire),
        .retire_no_rd(retire_no_rd),
        .accepted(accepted),
        .ready(ready),
        .done(done),
        .rdata(rdata),
        .illegal(illegal)
    );

    // ********************
    // clock and edge count
    // ********************
    initial clk = 1'b0;
    always #5 clk = ~clk;

    // read only at falling edges
    always @(posedge clk) edge_count <= edge_count + 1;

    // ********************
    // checks
    // ********************
    task automatic halt_with_failure();
        $display("Test FAILED");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_data(input csr_pkg::xlen_t got, input csr_pkg::xlen_t exp,
                              input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %h expected %h", $time, what, got, exp);
            halt_with_failure();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("FAILED at %0d ns: %s, got %b expected %b", $time, what, got, exp);
            halt_with_failure();
        end
    endtask

    // bound protocol assertions
    always @(negedge clk) begin
        if (DUT.u_sva.err_count != 0) begin
            $display("A bound protocol assertion failed.");
            halt_with_failure();
        end
    end

    // ********************
    // request driver
    // ********************
    task automatic wait_ready();
        int n;
        n = 0;
        while (!ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!ready) begin
            $display("Timeout: the unit never became ready for a new request.");
            halt_with_failure();
        end
    endtask

    task automatic wait_done();
        int n;
        n = 0;
        while (!done && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!done) begin
            $display("Timeout: no result came back after a request.");
            halt_with_failure();
        end
    endtask

    // one request with random writeback stall, called at a falling edge
    task automatic do_request(input csr_pkg::csr_op_t r_op, input csr_pkg::csr_addr_t r_addr,
                              input csr_pkg::xlen_t r_wdata, input csr_pkg::priv_t r_priv,
                              output csr_pkg::xlen_t r_data, output logic r_ill,
                              output integer r_edge);
        int delay;
        wait_ready();
        req = 1'b1;
        op = r_op;
        addr = r_addr;
        wdata = r_wdata;
        priv = r_priv;
        // sampled on the next rising edge
        r_edge = edge_count;
        @(negedge clk);
        req = 1'b0;
        wait_done();
        r_data = rdata;
        r_ill = illegal;
        // back-pressure 0..5 cycles
        delay = {$random(seed)} % 6;
        repeat (delay) begin
            @(negedge clk);
            check_flag(done, 1'b1, "done dropped while stalled");
            check_flag(ready, 1'b0, "ready rose while stalled");
            check_data(rdata, r_data, "rdata moved while stalled");
        end
        check_flag(ready, 1'b0, "ready high before accepted");
        accepted = 1'b1;
        @(negedge clk);
        accepted = 1'b0;
        check_flag(done, 1'b0, "done still high after accepted");
        check_flag(ready, 1'b1, "ready low after accepted");
    endtask

    // ********************
    // table and model
    // ********************
    function automatic csr_pkg::xlen_t apply_op(input csr_pkg::csr_op_t f_op,
                                                input csr_pkg::xlen_t old,
                                                input csr_pkg::xlen_t w);
        case (f_op)
            csr_pkg::CSR_OP_RS: return old | w;
            csr_pkg::CSR_OP_RC: return old & ~w;
            default: return w;
        endcase
    endfunction

    task automatic add_row(input csr_pkg::csr_op_t r_op, input csr_pkg::csr_addr_t r_addr,
                           input csr_pkg::xlen_t r_wdata, input csr_pkg::priv_t r_priv,
                           input csr_pkg::xlen_t r_exp, input logic r_ill, input logic r_chk);
        tab_op[n_rows] = r_op;
        tab_addr[n_rows] = r_addr;
        tab_wdata[n_rows] = r_wdata;
        tab_priv[n_rows] = r_priv;
        tab_exp[n_rows] = r_exp;
        tab_ill[n_rows] = r_ill;
        tab_chk[n_rows] = r_chk;
        n_rows = n_rows + 1;
    endtask

    task automatic build_table();
        csr_pkg::xlen_t m_mscratch;
        csr_pkg::xlen_t m_sscratch;
        csr_pkg::xlen_t m_mtvec;
        csr_pkg::xlen_t w;
        m_mscratch = '0;
        m_sscratch = '0;
        m_mtvec = `CSR_MTVEC_RESET;
        n_rows = 0;
        // constant information, machine level
        add_row(OP_RS, csr_pkg::ADDR_MISA, '0, PRIV_M, csr_pkg::MISA_VALUE, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MHARTID, '0, PRIV_M, `CSR_HART_ID, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MVENDORID, '0, PRIV_M, '0, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MARCHID, '0, PRIV_M, '0, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MIMPID, '0, PRIV_M, '0, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MTVEC, '0, PRIV_M, m_mtvec, 1'b0, 1'b1);
        // mscratch write then set and clear, reply is the old value
        w = $random(seed);
        add_row(OP_RW, csr_pkg::ADDR_MSCRATCH, w, PRIV_M, m_mscratch, 1'b0, 1'b1);
        m_mscratch = apply_op(OP_RW, m_mscratch, w);
        w = $random(seed);
        add_row(OP_RS, csr_pkg::ADDR_MSCRATCH, w, PRIV_M, m_mscratch, 1'b0, 1'b1);
        m_mscratch = apply_op(OP_RS, m_mscratch, w);
        w = $random(seed);
        add_row(OP_RC, csr_pkg::ADDR_MSCRATCH, w, PRIV_M, m_mscratch, 1'b0, 1'b1);
        m_mscratch = apply_op(OP_RC, m_mscratch, w);
        // sscratch is separate storage
        w = $random(seed);
        add_row(OP_RW, csr_pkg::ADDR_SSCRATCH, w, PRIV_M, m_sscratch, 1'b0, 1'b1);
        m_sscratch = w;
        add_row(OP_RS, csr_pkg::ADDR_MSCRATCH, '0, PRIV_M, m_mscratch, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_SSCRATCH, '0, PRIV_M, m_sscratch, 1'b0, 1'b1);
        // mtvec low two bits read back as zero
        w = $random(seed) | 32'h3;
        add_row(OP_RW, csr_pkg::ADDR_MTVEC, w, PRIV_M, m_mtvec, 1'b0, 1'b1);
        m_mtvec = w & ~32'h3;
        add_row(OP_RS, csr_pkg::ADDR_MTVEC, '0, PRIV_M, m_mtvec, 1'b0, 1'b1);
        // user level, machine regs denied and unchanged
        add_row(OP_RS, csr_pkg::ADDR_MSCRATCH, '0, PRIV_U, '0, 1'b1, 1'b0);
        w = $random(seed);
        add_row(OP_RW, csr_pkg::ADDR_MSCRATCH, w, PRIV_U, '0, 1'b1, 1'b0);
        add_row(OP_RS, csr_pkg::ADDR_MSCRATCH, '0, PRIV_M, m_mscratch, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_CYCLE, '0, PRIV_U, '0, 1'b0, 1'b0);
        // machine counter needs machine level
        add_row(OP_RS, csr_pkg::ADDR_MCYCLE, '0, PRIV_U, '0, 1'b1, 1'b0);
        // unmapped address
        add_row(OP_RS, 12'h7C0, '0, PRIV_M, '0, 1'b1, 1'b1);
        // misa ignores writes
        add_row(OP_RW, csr_pkg::ADDR_MISA, 32'hFFFF_FFFF, PRIV_M, csr_pkg::MISA_VALUE, 1'b0, 1'b1);
        add_row(OP_RS, csr_pkg::ADDR_MISA, '0, PRIV_M, csr_pkg::MISA_VALUE, 1'b0, 1'b1);
    endtask

    // ********************
    // main sequence
    // ********************
    initial begin
        rst = 1'b1;
        req = 1'b0;
        addr = '0;
        op = '0;
        wdata = '0;
        priv = PRIV_M;
        retire = 1'b0;
        retire_no_rd = 1'b0;
        accepted = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_flag(ready, 1'b1, "ready after reset");
        check_flag(done, 1'b0, "done after reset");
        check_flag(illegal, 1'b0, "illegal after reset");

        build_table();
        for (i = 0; i < n_rows; i++) begin
            do_request(tab_op[i], tab_addr[i], tab_wdata[i], tab_priv[i], got_data, got_ill, e1);
            check_flag(got_ill, tab_ill[i], $sformatf("row %0d illegal flag", i));
            if (tab_chk[i]) begin
                check_data(got_data, tab_exp[i], $sformatf("row %0d read data", i));
            end
        end

        // cycle and time deltas track counted request edges
        do_request(OP_RS, csr_pkg::ADDR_CYCLE, '0, PRIV_U, cnt_a, got_ill, e1);
        repeat (7) @(negedge clk);
        do_request(OP_RS, csr_pkg::ADDR_CYCLE, '0, PRIV_U, cnt_b, got_ill, e2);
        check_data(cnt_b - cnt_a, csr_pkg::xlen_t'(e2 - e1), "cycle delta");
        do_request(OP_RS, csr_pkg::ADDR_TIME, '0, PRIV_U, cnt_a, got_ill, e1);
        repeat (4) @(negedge clk);
        do_request(OP_RS, csr_pkg::ADDR_TIME, '0, PRIV_U, cnt_b, got_ill, e2);
        check_data(cnt_b - cnt_a, csr_pkg::xlen_t'(e2 - e1), "time delta");
        do_request(OP_RS, csr_pkg::ADDR_CYCLEH, '0, PRIV_M, got_data, got_ill, e1);
        check_data(got_data, '0, "cycleh read");
        check_flag(got_ill, 1'b0, "cycleh illegal flag");

        // retire burst, idle gaps let the late increment settle
        do_request(OP_RS, csr_pkg::ADDR_MINSTRET, '0, PRIV_M, cnt_a, got_ill, e1);
        repeat (3) @(negedge clk);
        weight = 0;
        for (i = 0; i < BURST; i++) begin
            retire = RET_PAT[i];
            retire_no_rd = NRD_PAT[i];
            weight = weight + RET_PAT[i] + NRD_PAT[i];
            @(negedge clk);
        end
        retire = 1'b0;
        retire_no_rd = 1'b0;
        repeat (3) @(negedge clk);
        do_request(OP_RS, csr_pkg::ADDR_MINSTRET, '0, PRIV_M, cnt_b, got_ill, e2);
        check_data(cnt_b - cnt_a, csr_pkg::xlen_t'(weight), "instret delta");

        // late protocol assertion failures
        if (DUT.u_sva.err_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            $display("A bound protocol assertion failed during the run.");
            halt_with_failure();
        end
    end

endmodule

`default_nettype wire
